// ==== vlog.f ====
+incdir+sim
verilog/adc_snap_pkg.sv
verilog/wb_snap_regs.sv
verilog/snap_sequencer.sv
verilog/snap_mem_arbiter.sv
verilog/snap_bram.sv
verilog/adc_snap_top.sv
sim/tb_adc_snap.sv

// ==== sim/tb_adc_snap_tests.svh ====
// Bus driver tasks and directed tests, included inside tb_adc_snap.
// Every task starts and ends on a falling clock edge.

localparam logic [31:0] CTRL_ADDR   = 32'(adc_snap_pkg::REG_CTRL * 4);
localparam logic [31:0] STATUS_ADDR = 32'(adc_snap_pkg::REG_STATUS * 4);

// One Wishbone access; waited counts the clocks from strobe to ack.
task automatic wb_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] sel, output logic [31:0] rdata, output int waited);
  rdata = '0;
  @(negedge user_clk);
  wb_adr_i = addr;
  wb_dat_i = wdata;
  wb_sel_i = sel;
  wb_we_i  = we;
  wb_cyc_i = 1'b1;
  wb_stb_i = 1'b1;
  @(negedge user_clk);
  waited = 1;
  while (!wb_ack_o && waited < BUS_LIMIT)
  begin
    @(negedge user_clk);
    waited++;
  end
  if (!wb_ack_o)
  begin
    bus_errors++;
    $display("%0t ns: no ack for the access to %h within %0d clocks.", $time, addr, BUS_LIMIT);
  end
  else
  begin
    rdata = wb_dat_o;
    check_word("wb_err_o at ack", {31'b0, wb_err_o}, 32'h0);
  end
  wb_cyc_i = 1'b0;
  wb_stb_i = 1'b0;
  wb_we_i  = 1'b0;
endtask

task automatic wb_write(input logic [31:0] addr, input logic [31:0] data,
                        input logic [3:0] sel);
  logic [31:0] unused;
  int          waited;
  wb_access(1'b1, addr, data, sel, unused, waited);
endtask

task automatic wb_read(input logic [31:0] addr, output logic [31:0] data,
                       output int waited);
  wb_access(1'b0, addr, '0, 4'hf, data, waited);
endtask

// Expected word idx of a capture whose word 0 has lane0 equal to l0.
function automatic adc_snap_pkg::sample_t lane_sample(input logic [7:0] l0, input int idx);
  logic [7:0]            b;
  adc_snap_pkg::sample_t s;
  b       = l0 + 8'(4 * idx);
  s.lane0 = b;
  s.lane1 = b + 8'd1;
  s.lane2 = b + 8'd2;
  s.lane3 = b + 8'd3;
  return s;
endfunction

task automatic new_adc_base();
  adc_base = $random(seed);
endtask

// Set then clear the request bit; the falling edge starts the capture.
task automatic trigger_capture();
  wb_write(CTRL_ADDR, 32'h1, 4'hf);
  wb_write(CTRL_ADDR, 32'h0, 4'hf);
  repeat (2) @(negedge user_clk);  // Lets the old done flag clear.
endtask

task automatic wait_done();
  logic [31:0] st;
  int          waited;
  int          polls;
  polls = 0;
  st    = '0;
  while (!st[adc_snap_pkg::STAT_DONE] && polls < SNAP_DEPTH)
  begin
    wb_read(STATUS_ADDR, st, waited);
    polls++;
  end
  if (!st[adc_snap_pkg::STAT_DONE])
  begin
    bus_errors++;
    $display("%0t ns: capture did not finish within %0d status reads.", $time, polls);
  end
  check_word("status after capture", st, 32'h2);
endtask

task automatic read_snapshot();
  logic [31:0] d;
  int          waited;
  for (int i = 0; i < SNAP_DEPTH; i++)
  begin
    wb_read(adc_snap_pkg::MEM_BASE + 32'(4 * i), d, waited);
    snap_buf[i] = d;
  end
endtask

task automatic check_lane_rule(input string tag);
  logic [7:0] l0;
  l0 = snap_buf[0].lane0;
  for (int i = 0; i < SNAP_DEPTH; i++)
    check_sample($sformatf("%s word %0d", tag, i), snap_buf[i], lane_sample(l0, i));
endtask

task automatic reset_state_test();
  logic [31:0] d;
  int          waited;
  @(negedge user_clk);
  check_word("wb_ack_o after reset", {31'b0, wb_ack_o}, 32'h0);
  check_word("snap_we_o after reset", {31'b0, snap_we_o}, 32'h0);
  check_word("wb_dat_o without ack", wb_dat_o, 32'h0);
  wb_read(CTRL_ADDR, d, waited);
  check_word("control after reset", d, 32'h0);
  wb_read(STATUS_ADDR, d, waited);
  check_word("status after reset", d, 32'h0);
endtask

// Bit 0 stays low throughout, so no capture starts here.
task automatic ctrl_reg_test();
  logic [31:0] d;
  int          waited;
  wb_write(CTRL_ADDR, 32'ha5a5_a5a4, 4'hf);
  wb_write(CTRL_ADDR, 32'h5a5a_5a5b, 4'b1010);
  wb_read(CTRL_ADDR, d, waited);
  check_word("control after byte select write", d, 32'h5aa5_5aa4);  // Bytes 3 and 1 replaced.
  wb_write(CTRL_ADDR, 32'h0, 4'hf);
  wb_read(32'h0000_0008, d, waited);
  check_word("unmapped read at 0x08", d, 32'h0);
  wb_read(32'h0000_0200, d, waited);
  check_word("unmapped read at 0x200", d, 32'h0);
endtask

task automatic capture_test();
  logic [31:0] st;
  int          waited;
  new_adc_base();
  trigger_capture();
  wb_read(STATUS_ADDR, st, waited);
  check_word("status during capture", st, 32'h1);
  wait_done();
  read_snapshot();
  check_lane_rule("first capture");
  first_snap = snap_buf;
endtask

task automatic held_request_test();
  logic [31:0] st;
  int          waited;
  wb_write(CTRL_ADDR, 32'h1, 4'hf);
  repeat (8) @(negedge user_clk);
  wb_read(STATUS_ADDR, st, waited);
  check_word("status with request held", st, 32'h2);
  read_snapshot();
  for (int i = 0; i < SNAP_DEPTH; i++)
    check_sample($sformatf("held word %0d", i), snap_buf[i], lane_sample(first_snap[0].lane0, i));
endtask

// Request bit is still set, so the clearing write alone triggers.
task automatic backpressure_test();
  logic [31:0] rd;
  logic [31:0] w0;
  int          waited;
  new_adc_base();
  wb_write(CTRL_ADDR, 32'h0, 4'hf);
  wb_read(adc_snap_pkg::MEM_BASE + 32'd20, rd, waited);
  check_word("read held through capture", {31'b0, waited >= SNAP_DEPTH}, 32'h1);
  check_word("snap_we_o at read ack", {31'b0, snap_we_o}, 32'h0);
  wait_done();
  wb_read(adc_snap_pkg::MEM_BASE, w0, waited);
  check_sample("word 0 after back-pressure", w0, lane_sample(w0[7:0], 0));
  check_sample("back-pressured word 5", rd, lane_sample(w0[7:0], 5));
endtask

task automatic recapture_test();
  new_adc_base();
  trigger_capture();
  wait_done();
  read_snapshot();
  check_lane_rule("second capture");
  check_word("word 0 changed", {31'b0, snap_buf[0] !== first_snap[0]}, 32'h1);
endtask

// ==== sim/tb_adc_snap.sv ====
// Testbench for adc_snap_top. Bus and ADC inputs change on the falling clock edge.
// Expected snapshot words follow the lane rule of the ADC stimulus.
`timescale 1ns/100ps

module tb_adc_snap;

  localparam int SNAP_DEPTH   = 64;
  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int BUS_LIMIT    = 2 * SNAP_DEPTH + 8;  // Longest wait for one ack.
  // Rough clocks per test, reset first; the watchdog allows twice their sum.
  localparam int TEST_CYCLES  = RESET_CYCLES + 20 + 40 + 400 + 300 + 200 + 400;
  localparam longint WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

  logic                              user_clk;
  logic                              rst;
  logic [31:0]                       wb_adr_i;
  logic [31:0]                       wb_dat_i;
  logic [3:0]                        wb_sel_i;
  logic                              wb_we_i;
  logic                              wb_cyc_i;
  logic                              wb_stb_i;
  logic [31:0]                       wb_dat_o;
  logic                              wb_ack_o;
  logic                              wb_err_o;
  adc_snap_pkg::sample_t             adc_data_i;
  logic                              snap_we_o;
  logic [adc_snap_pkg::ADDR_W-1:0]   snap_addr_o;

  integer                seed = 85;
  logic [31:0]           adc_base;
  int                    adc_cycle;
  int                    value_errors;
  int                    bus_errors;
  int                    exp_wr_addr;                // Next address of the capture sweep.
  adc_snap_pkg::sample_t snap_buf [SNAP_DEPTH];    // Latest memory readback.
  adc_snap_pkg::sample_t first_snap [SNAP_DEPTH];  // Readback of the first capture.

  adc_snap_top #(
    .SNAP_DEPTH (SNAP_DEPTH)
  ) dut (
    .user_clk    (user_clk),
    .rst         (rst),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_we_i     (wb_we_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o),
    .adc_data_i  (adc_data_i),
    .snap_we_o   (snap_we_o),
    .snap_addr_o (snap_addr_o)
  );

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_sample(input string what, input adc_snap_pkg::sample_t got,
                              input adc_snap_pkg::sample_t exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("[ERROR] %0t ns: %s lanes 3..0 are %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Stimulus word for the ADC, lane j carries the low byte plus j.
  function automatic adc_snap_pkg::sample_t adc_sample(input logic [31:0] v);
    adc_snap_pkg::sample_t s;
    s.lane0 = v[7:0];
    s.lane1 = v[7:0] + 8'd1;
    s.lane2 = v[7:0] + 8'd2;
    s.lane3 = v[7:0] + 8'd3;
    return s;
  endfunction

  `include "tb_adc_snap_tests.svh"

  initial
  begin
    user_clk = 1'b0;
    forever #(CLK_PERIOD / 2) user_clk = ~user_clk;
  end

  initial
  begin
    adc_base   = '0;
    adc_cycle  = 0;
    adc_data_i = '0;
    forever
    begin
      @(negedge user_clk);
      adc_data_i = adc_sample(adc_base + 32'(4 * adc_cycle));  // Advances by 4 per clock.
      adc_cycle++;
    end
  end

  // Capture writes sweep all addresses in order, one per clock, without a gap.
  initial
  begin
    exp_wr_addr = 0;
    forever
    begin
      @(negedge user_clk);
      if (!rst)
      begin
        if (snap_we_o)
        begin
          check_word("snap_addr_o on a capture write", 32'(snap_addr_o), 32'(exp_wr_addr));
          exp_wr_addr = (exp_wr_addr + 1) % SNAP_DEPTH;
        end
        else
        begin
          check_word("next sweep address while snap_we_o is low", 32'(exp_wr_addr), 32'h0);
          exp_wr_addr = 0;
        end
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish.", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

  initial
  begin
    rst          = 1'b1;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    wb_sel_i     = '0;
    wb_we_i      = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    value_errors = 0;
    bus_errors   = 0;
    repeat (RESET_CYCLES) @(negedge user_clk);
    rst = 1'b0;
    reset_state_test();
    ctrl_reg_test();
    capture_test();
    held_request_test();
    backpressure_test();
    recapture_test();
    $display("Errors: %0d value mismatches, %0d bus timeouts", value_errors, bus_errors);
    if (value_errors + bus_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== verilog/adc_snap_top.sv ====
// ADC snapshot capture with Wishbone readback, all in the user_clk domain.
// The ADC input must carry a new sample on every clock.
// snap_we_o and snap_addr_o mirror the sequencer write port for debug.
`timescale 1ns/100ps

module adc_snap_top #(
  parameter int SNAP_DEPTH = 64
) (
  input  logic                                user_clk,
  input  logic                                rst,
  input  logic [31:0]                         wb_adr_i,
  input  logic [31:0]                         wb_dat_i,
  input  logic [3:0]                          wb_sel_i,
  input  logic                                wb_we_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  output logic [31:0]                         wb_dat_o,
  output logic                                wb_ack_o,
  output logic                                wb_err_o,
  input  adc_snap_pkg::sample_t               adc_data_i,
  output logic                                snap_we_o,
  output logic [adc_snap_pkg::ADDR_W-1:0]     snap_addr_o
);

  adc_snap_pkg::mem_req_t seq_req;
  adc_snap_pkg::mem_req_t bus_req;
  adc_snap_pkg::mem_req_t mem_req;
  adc_snap_pkg::sample_t  mem_rdata;
  logic                   bus_gnt;
  logic                   snap_req;
  logic                   busy;
  logic                   done;

  wb_snap_regs u_regs (
    .user_clk    (user_clk),
    .rst         (rst),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_we_i     (wb_we_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o),
    .busy_i      (busy),
    .done_i      (done),
    .snap_req_o  (snap_req),
    .mem_req_o   (bus_req),
    .mem_gnt_i   (bus_gnt),
    .mem_rdata_i (mem_rdata)
  );

  snap_sequencer #(
    .SNAP_DEPTH (SNAP_DEPTH)
  ) u_seq (
    .user_clk   (user_clk),
    .rst        (rst),
    .snap_req_i (snap_req),
    .adc_data_i (adc_data_i),
    .wr_req_o   (seq_req),
    .busy_o     (busy),
    .done_o     (done)
  );

  snap_mem_arbiter u_arb (
    .user_clk  (user_clk),
    .rst       (rst),
    .seq_req_i (seq_req),
    .bus_req_i (bus_req),
    .bus_gnt_o (bus_gnt),
    .mem_req_o (mem_req)
  );

  snap_bram u_bram (
    .user_clk  (user_clk),
    .mem_req_i (mem_req),
    .rdata_o   (mem_rdata)
  );

  assign snap_we_o   = seq_req.valid;  // Debug view of the capture writes.
  assign snap_addr_o = seq_req.addr;

endmodule

// ==== verilog/snap_bram.sv ====
// Single-port snapshot memory of 2**ADDR_W sample words.
// Read data is registered and appears one clock after a valid read request;
// it holds its value between reads. No reset, so it maps onto a block RAM.
`timescale 1ns/100ps

module snap_bram (
  input  logic                   user_clk,
  input  adc_snap_pkg::mem_req_t mem_req_i,
  output adc_snap_pkg::sample_t  rdata_o
);

  localparam int DEPTH = 2 ** adc_snap_pkg::ADDR_W;

  adc_snap_pkg::sample_t mem [DEPTH];

  always_ff @(posedge user_clk)
  begin
    if (mem_req_i.valid)
    begin
      if (mem_req_i.we)
        mem[mem_req_i.addr] <= mem_req_i.wdata;  // Capture write.
      else
        rdata_o <= mem[mem_req_i.addr];  // Bus readback.
    end
  end

endmodule

// ==== verilog/snap_mem_arbiter.sv ====
// Shares the snapshot memory port between the sequencer and bus readback.
// The sequencer always wins and is never stalled. A bus request is granted
// once with a one-clock pulse and must drop before it can be granted again.
`timescale 1ns/100ps

module snap_mem_arbiter (
  input  logic                   user_clk,
  input  logic                   rst,
  input  adc_snap_pkg::mem_req_t seq_req_i,
  input  adc_snap_pkg::mem_req_t bus_req_i,
  output logic                   bus_gnt_o,
  output adc_snap_pkg::mem_req_t mem_req_o
);

  logic bus_granted_q;  // Current bus request has had its grant.

  assign bus_gnt_o = bus_req_i.valid && !seq_req_i.valid && !bus_granted_q;

  always_comb
  begin
    if (seq_req_i.valid)
      mem_req_o = seq_req_i;
    else if (bus_gnt_o)
      mem_req_o = bus_req_i;
    else
      mem_req_o = adc_snap_pkg::MEM_REQ_IDLE;
  end

  always_ff @(posedge user_clk)
  begin
    if (rst)
      bus_granted_q <= 1'b0;
    else if (!bus_req_i.valid)
      bus_granted_q <= 1'b0;  // Requester has taken its grant and let go.
    else if (bus_gnt_o)
      bus_granted_q <= 1'b1;
  end

  // A granted bus request reaches the memory as a read, never beside a capture write.
  a_seq_first: assert property (@(posedge user_clk) disable iff (rst)
    bus_gnt_o |-> (mem_req_o.valid && !mem_req_o.we))
    else $error("bus grant given while the memory port carries a write");

  // A granted bus request is served once, so the grant pulse is a single clock.
  a_gnt_pulse: assert property (@(posedge user_clk) disable iff (rst)
    bus_gnt_o |=> !bus_gnt_o)
    else $error("bus grant held for more than one clock");

endmodule

// ==== verilog/snap_sequencer.sv ====
// Starts a capture on a falling edge of the request bit and writes SNAP_DEPTH
// consecutive samples at addresses 0 upward. Idle after reset.
// SNAP_DEPTH must not exceed 2**ADDR_W.
`timescale 1ns/100ps

module snap_sequencer #(
  parameter int SNAP_DEPTH = 64
) (
  input  logic                   user_clk,
  input  logic                   rst,
  input  logic                   snap_req_i,
  input  adc_snap_pkg::sample_t  adc_data_i,
  output adc_snap_pkg::mem_req_t wr_req_o,
  output logic                   busy_o,
  output logic                   done_o
);

  localparam int AW = adc_snap_pkg::ADDR_W;
  localparam logic [AW-1:0] LAST_ADDR = AW'(SNAP_DEPTH - 1);

  logic [1:0]    req_sync;  // Request history, newest in bit 0.
  logic          req_fall;
  logic          active;
  logic [AW-1:0] wr_addr;

  assign req_fall = (req_sync == 2'b10);

  always_ff @(posedge user_clk)
  begin
    if (rst)
    begin
      req_sync <= 2'b00;
      active   <= 1'b0;
      wr_addr  <= '0;
      done_o   <= 1'b0;
    end
    else
    begin
      req_sync <= {req_sync[0], snap_req_i};
      if (req_fall)
      begin
        active  <= 1'b1;  // Restarts from address 0 even mid capture.
        wr_addr <= '0;
        done_o  <= 1'b0;
      end
      else if (active)
      begin
        if (wr_addr == LAST_ADDR)
        begin
          active <= 1'b0;
          done_o <= 1'b1;
        end
        else
          wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // The sample is written in the same clock it is presented.
  assign wr_req_o = '{valid: active, we: 1'b1, addr: wr_addr, wdata: adc_data_i};
  assign busy_o   = active;

  a_addr_range: assert property (@(posedge user_clk) disable iff (rst)
    wr_req_o.valid |-> (int'(wr_req_o.addr) < SNAP_DEPTH))
    else $error("snapshot write address beyond SNAP_DEPTH");

endmodule

// ==== verilog/wb_snap_regs.sv ====
// Wishbone classic slave, single-cycle ack, clocked by user_clk.
// Memory window reads wait for the arbiter grant, so their ack latency varies.
// Writes to the memory window and all unmapped accesses are acked and ignored.
`timescale 1ns/100ps

module wb_snap_regs (
  input  logic                   user_clk,
  input  logic                   rst,
  input  logic [31:0]            wb_adr_i,
  input  logic [31:0]            wb_dat_i,
  input  logic [3:0]             wb_sel_i,
  input  logic                   wb_we_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  output logic [31:0]            wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   wb_err_o,
  input  logic                   busy_i,
  input  logic                   done_i,
  output logic                   snap_req_o,
  output adc_snap_pkg::mem_req_t mem_req_o,
  input  logic                   mem_gnt_i,
  input  adc_snap_pkg::sample_t  mem_rdata_i
);

  localparam int AW = adc_snap_pkg::ADDR_W;

  logic [31:0]   ctrl_q;
  logic [31:0]   dat_q;
  logic          wb_ack;
  logic          ack_mem;   // Current ack carries memory data.
  logic          rd_pend;   // Memory read waits for a grant.
  logic [AW-1:0] rd_addr;
  logic          access;
  logic          sel_ctrl;
  logic          sel_status;
  logic          sel_mem;
  logic [31:0]   status_word;
  logic [31:0]   rdata_word;

  assign access     = wb_cyc_i && wb_stb_i;
  assign sel_ctrl   = (wb_adr_i[31:2] == 30'(adc_snap_pkg::REG_CTRL));
  assign sel_status = (wb_adr_i[31:2] == 30'(adc_snap_pkg::REG_STATUS));
  assign sel_mem    = (wb_adr_i[31:AW+2] == adc_snap_pkg::MEM_BASE[31:AW+2]);

  assign status_word = {30'b0, done_i, busy_i};
  assign rdata_word  = mem_rdata_i;

  always_ff @(posedge user_clk)
  begin
    if (rst)
    begin
      wb_ack  <= 1'b0;
      ack_mem <= 1'b0;
      rd_pend <= 1'b0;
      ctrl_q  <= '0;
    end
    else
    begin
      wb_ack  <= 1'b0;
      ack_mem <= 1'b0;
      if (rd_pend)
      begin
        if (mem_gnt_i)
        begin
          rd_pend <= 1'b0;
          wb_ack  <= 1'b1;  // Data arrives from the memory in this clock.
          ack_mem <= 1'b1;
        end
      end
      else if (access && !wb_ack)
      begin
        if (sel_mem && !wb_we_i)
          rd_pend <= 1'b1;  // Ack follows the grant.
        else
          wb_ack <= 1'b1;
        if (wb_we_i && sel_ctrl)
        begin
          for (int i = 0; i < 4; i++)
          begin
            if (wb_sel_i[i])
              ctrl_q[8*i +: 8] <= wb_dat_i[8*i +: 8];
          end
        end
      end
    end
  end

  // Read data and memory address need no reset.
  always_ff @(posedge user_clk)
  begin
    if (access && !wb_ack && !rd_pend && !wb_we_i)
    begin
      if (sel_ctrl)
        dat_q <= ctrl_q;
      else if (sel_status)
        dat_q <= status_word;
      else
        dat_q <= '0;  // Unmapped reads return zero.
      rd_addr <= wb_adr_i[AW+1:2];
    end
  end

  always_comb
  begin
    mem_req_o      = adc_snap_pkg::MEM_REQ_IDLE;
    mem_req_o.valid = rd_pend;
    mem_req_o.addr  = rd_addr;
  end

  assign snap_req_o = ctrl_q[0];
  assign wb_ack_o   = wb_ack;
  assign wb_err_o   = 1'b0;
  assign wb_dat_o   = wb_ack ? (ack_mem ? rdata_word : dat_q) : 32'b0;

  // Every access sees a single ack, even when the master holds stb through it.
  a_single_ack: assert property (@(posedge user_clk) disable iff (rst)
    wb_ack |=> !wb_ack)
    else $error("wb_ack_o high for two clocks in a row");

endmodule

// ==== verilog/adc_snap_pkg.sv ====
// Shared types and address map for the ADC snapshot subsystem.
// The snapshot window holds 2**ADDR_W words; MEM_BASE must be aligned to it.
package adc_snap_pkg;

  // Width of a snapshot memory word address.
  localparam int ADDR_W = 6;

  // Register word addresses, bus byte address divided by four.
  localparam int REG_CTRL   = 0;  // Bit 0 is the snapshot request.
  localparam int REG_STATUS = 1;  // Bit 0 busy, bit 1 done.

  // Byte offset of the snapshot readback window.
  localparam logic [31:0] MEM_BASE = 32'h0000_0100;

  // Status register bit positions.
  localparam int STAT_BUSY = 0;
  localparam int STAT_DONE = 1;

  // One ADC clock worth of samples, lane0 in the low byte.
  typedef struct packed {
    logic [7:0] lane3;
    logic [7:0] lane2;
    logic [7:0] lane1;
    logic [7:0] lane0;
  } sample_t;

  // Request on the single snapshot memory port.
  typedef struct packed {
    logic              valid;  // Request is active this clock.
    logic              we;     // High for a write, low for a read.
    logic [ADDR_W-1:0] addr;   // Word address.
    sample_t           wdata;  // Write word, ignored on reads.
  } mem_req_t;

  // Idle request, used where nothing is driven on the port.
  localparam mem_req_t MEM_REQ_IDLE = '{valid: 1'b0, we: 1'b0, addr: '0, wdata: '0};

endpackage
